// ==== Bender.yml ====
package:
  name: rn

sources:
  - include_dirs:
      - logic
    files:
      - logic/rn_pkg.sv
      - logic/rn_cmt_if.sv
      - logic/rn_fl.sv
      - logic/rn_rat.sv
      - logic/rn_busytable.sv
      - logic/rn.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/rn_tb.sv

// ==== dv/rn_tb.sv ====
// Testbench for the rename stage
//   Step table of rename groups, commits, writebacks, credit returns and flushes
//   Reference model of alias tables, free list, busy bits and credits
//   Per-step checks of stall, issue fields and busy table

`timescale 1ns/1ps
`default_nettype none

`include "rn_defines.svh"

module rn_tb;

   localparam int IW           = `RN_IW;
   localparam int NLREG        = 1 << `RN_LRF_AW;
   localparam int NPREG        = 1 << `RN_PRF_AW;
   localparam int PUSH_TIMEOUT = 4;

   typedef struct {
      string                      name;
      logic [IW-1:0]              valid;
      logic [IW-1:0]              we;
      rn_pkg::lreg_t [IW-1:0]     lrs1;      // Slot 1 in the upper half
      rn_pkg::lreg_t [IW-1:0]     lrs2;
      rn_pkg::lreg_t [IW-1:0]     lrd;
      logic                       cmt;       // Retire the oldest renamed uop
      logic [IW-1:0]              wb_we;
      rn_pkg::preg_t [IW-1:0]     wb_addr;
      logic [IW-1:0]              credit;
      logic                       flush;
   } step_t;

   // In-order record of renamed writers, retired by commit steps
   typedef struct packed {
      rn_pkg::lreg_t lrd;
      rn_pkg::preg_t prd;
      rn_pkg::preg_t pfree;
   } rob_t;

   logic                              clk;
   logic                              rst;
   logic                              flush;
   logic [IW-1:0]                     rn_valid;
   rn_pkg::uop_payload_t [IW-1:0]     rn_payload;
   rn_pkg::lreg_t [IW-1:0]            rn_lrs1;
   logic [IW-1:0]                     rn_lrs1_re;
   rn_pkg::lreg_t [IW-1:0]            rn_lrs2;
   logic [IW-1:0]                     rn_lrs2_re;
   rn_pkg::lreg_t [IW-1:0]            rn_lrd;
   logic [IW-1:0]                     rn_lrd_we;
   logic                              rn_stall_req;
   logic                              cmt_fire;
   rn_pkg::lreg_t                     cmt_lrd;
   rn_pkg::preg_t                     cmt_prd;
   logic                              cmt_prd_we;
   rn_pkg::preg_t                     cmt_pfree;
   rn_pkg::preg_t [IW-1:0]            prf_waddr;
   logic [IW-1:0]                     prf_we;
   logic [IW-1:0]                     issue_credit;
   logic [IW-1:0]                     issue_push;
   rn_pkg::uop_payload_t [IW-1:0]     issue_payload;
   rn_pkg::preg_t [IW-1:0]            issue_prs1;
   logic [IW-1:0]                     issue_prs1_re;
   rn_pkg::preg_t [IW-1:0]            issue_prs2;
   logic [IW-1:0]                     issue_prs2_re;
   rn_pkg::lreg_t [IW-1:0]            issue_lrd;
   rn_pkg::preg_t [IW-1:0]            issue_prd;
   logic [IW-1:0]                     issue_prd_we;
   rn_pkg::preg_t [IW-1:0]            issue_pfree;
   logic [NPREG-1:0]                  busytable;

   step_t         steps [$];
   rob_t          rob [$];
   rn_pkg::preg_t spec_map [NLREG];
   rn_pkg::preg_t cmt_map [NLREG];
   rn_pkg::preg_t spec_free [$];
   rn_pkg::preg_t cmt_free [$];
   logic [NPREG-1:0] busy_m;
   int            credits_m;
   int            err_cnt;
   int            check_cnt;
   logic          timed_out;

   rn u_dut (.*);

   initial clk = 1'b0;
   always #50 clk = ~clk;

   task automatic compare(input string what, input logic [255:0] got, input logic [255:0] exp);
      check_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("** Error: %s got %0h expected %0h", what, got, exp);
      end
   endtask

   function automatic void add_step(input string name, input logic [IW-1:0] valid,
                                    input logic [IW-1:0] we, input rn_pkg::lreg_t [IW-1:0] lrs1,
                                    input rn_pkg::lreg_t [IW-1:0] lrs2,
                                    input rn_pkg::lreg_t [IW-1:0] lrd, input logic cmt = 1'b0,
                                    input logic [IW-1:0] wb_we = '0,
                                    input rn_pkg::preg_t [IW-1:0] wb_addr = '0,
                                    input logic [IW-1:0] credit = '0, input logic fl = 1'b0);
      step_t s;
      s.name = name;
      s.valid = valid;
      s.we = we;
      s.lrs1 = lrs1;
      s.lrs2 = lrs2;
      s.lrd = lrd;
      s.cmt = cmt;
      s.wb_we = wb_we;
      s.wb_addr = wb_addr;
      s.credit = credit;
      s.flush = fl;
      steps.push_back(s);
   endfunction

   task automatic drive_idle();
      flush        <= 1'b0;
      rn_valid     <= '0;
      rn_payload   <= '0;
      rn_lrs1      <= '0;
      rn_lrs1_re   <= '0;
      rn_lrs2      <= '0;
      rn_lrs2_re   <= '0;
      rn_lrd       <= '0;
      rn_lrd_we    <= '0;
      cmt_fire     <= 1'b0;
      cmt_lrd      <= '0;
      cmt_prd      <= '0;
      cmt_prd_we   <= 1'b0;
      cmt_pfree    <= '0;
      prf_waddr    <= '0;
      prf_we       <= '0;
      issue_credit <= '0;
   endtask

   task automatic run_step(input int idx);
      step_t                s;
      rob_t                 c;
      rob_t                 r;
      logic                 c_fire;
      logic                 exp_stall;
      logic                 acc;
      logic                 got_push;
      logic [159:0]         rnd;
      logic [IW-1:0]        re1;
      logic [IW-1:0]        re2;
      int                   nv;
      int                   nw;
      int                   err0;
      int                   wait_cyc;
      rn_pkg::preg_t        e_prs1 [IW];
      rn_pkg::preg_t        e_prs2 [IW];
      rn_pkg::preg_t        e_prd [IW];
      rn_pkg::preg_t        e_pfree [IW];
      rn_pkg::uop_payload_t pl [IW];
      s = steps[idx];
      err0 = err_cnt;
      c = '0;
      c_fire = s.cmt && (rob.size() > 0);
      if (c_fire)
         c = rob.pop_front();
      nv = $countones(s.valid);
      nw = $countones(s.valid & s.we);
      exp_stall = (spec_free.size() < nw) || (credits_m < nv);
      acc = (s.valid != '0) && !exp_stall && !s.flush;
      for (int j = 0; j < IW; j++)
      begin
         if (s.wb_we[j])
            busy_m[s.wb_addr[j]] = 1'b0;     // Set below wins on the same tag
      end
      // Slots in order, so a later slot sees the earlier slot's new mapping
      for (int i = 0; i < IW; i++)
      begin
         rnd = {$urandom, $urandom, $urandom, $urandom, $urandom};
         pl[i] = rn_pkg::uop_payload_t'(rnd[$bits(rn_pkg::uop_payload_t)-1:0]);
         e_prs1[i] = spec_map[s.lrs1[i]];
         e_prs2[i] = spec_map[s.lrs2[i]];
         e_pfree[i] = spec_map[s.lrd[i]];
         e_prd[i] = '0;
         if (acc && s.valid[i] && s.we[i])
         begin
            e_prd[i] = spec_free.pop_front();
            spec_map[s.lrd[i]] = e_prd[i];
            busy_m[e_prd[i]] = 1'b1;
            r.lrd = s.lrd[i];
            r.prd = e_prd[i];
            r.pfree = e_pfree[i];
            rob.push_back(r);
         end
      end
      re1 = IW'($urandom);                   // Source read enables pass through
      re2 = IW'($urandom);
      if (c_fire)
      begin
         cmt_map[c.lrd] = c.prd;
         void'(cmt_free.pop_front());
         cmt_free.push_back(c.pfree);
         spec_free.push_back(c.pfree);
      end
      credits_m = credits_m + $countones(s.credit) - (acc ? nv : 0);
      if (s.flush)
      begin
         spec_map = cmt_map;
         spec_free = cmt_free;
         busy_m = '0;
         credits_m = `RN_IQ_DEPTH;
         rob.delete();                       // In-flight uops are squashed
      end

      @(posedge clk);
      flush        <= s.flush;
      rn_valid     <= s.valid;
      rn_lrs1      <= s.lrs1;
      rn_lrs1_re   <= re1;
      rn_lrs2      <= s.lrs2;
      rn_lrs2_re   <= re2;
      rn_lrd       <= s.lrd;
      rn_lrd_we    <= s.we;
      for (int i = 0; i < IW; i++)
         rn_payload[i] <= pl[i];
      cmt_fire     <= c_fire;
      cmt_lrd      <= c.lrd;
      cmt_prd      <= c.prd;
      cmt_prd_we   <= c_fire;
      cmt_pfree    <= c.pfree;
      prf_we       <= s.wb_we;
      prf_waddr    <= s.wb_addr;
      issue_credit <= s.credit;
      @(negedge clk);
      compare("rn_stall_req", rn_stall_req, exp_stall);
      @(posedge clk);
      drive_idle();

      if (acc)
      begin
         wait_cyc = 0;
         got_push = 1'b0;
         while (!got_push && wait_cyc < PUSH_TIMEOUT)
         begin
            @(negedge clk);
            wait_cyc++;
            got_push = (issue_push != '0);
         end
         if (!got_push)
         begin
            $display("step %0d %s: no issue_push within %0d cycles", idx, s.name, PUSH_TIMEOUT);
            timed_out = 1'b1;
         end
         else
         begin
            compare("issue_push latency", wait_cyc, 1);
            compare("issue_push", issue_push, s.valid);
            for (int i = 0; i < IW; i++)
            begin
               if (s.valid[i])
               begin
                  compare($sformatf("issue_payload[%0d]", i), issue_payload[i], pl[i]);
                  compare($sformatf("issue_prs1[%0d]", i), issue_prs1[i], e_prs1[i]);
                  compare($sformatf("issue_prs1_re[%0d]", i), issue_prs1_re[i], re1[i]);
                  compare($sformatf("issue_prs2[%0d]", i), issue_prs2[i], e_prs2[i]);
                  compare($sformatf("issue_prs2_re[%0d]", i), issue_prs2_re[i], re2[i]);
                  compare($sformatf("issue_lrd[%0d]", i), issue_lrd[i], s.lrd[i]);
                  compare($sformatf("issue_prd_we[%0d]", i), issue_prd_we[i], s.we[i]);
                  if (s.we[i])
                  begin
                     compare($sformatf("issue_prd[%0d]", i), issue_prd[i], e_prd[i]);
                     compare($sformatf("issue_pfree[%0d]", i), issue_pfree[i], e_pfree[i]);
                  end
               end
            end
         end
      end
      else
      begin
         @(negedge clk);
         compare("issue_push", issue_push, '0);
      end
      compare("busytable", busytable, busy_m);
      $display("step %0d %-16s %s", idx, s.name, (err_cnt == err0) ? "ok" : "mismatch");
   endtask

   initial
   begin
      err_cnt = 0;
      check_cnt = 0;
      timed_out = 1'b0;
      void'($urandom(32'h2df7));
      rst <= 1'b1;
      drive_idle();
      for (int k = 0; k < NLREG; k++)
      begin
         spec_map[k] = rn_pkg::preg_t'(k);
         cmt_map[k] = rn_pkg::preg_t'(k);
      end
      for (int k = NLREG; k < NPREG; k++)
      begin
         spec_free.push_back(rn_pkg::preg_t'(k));
         cmt_free.push_back(rn_pkg::preg_t'(k));
      end
      busy_m = '0;
      credits_m = `RN_IQ_DEPTH;

      add_step("rename bypass", 2'b11, 2'b11, {5'd1, 5'd1}, {5'd3, 5'd2}, {5'd1, 5'd1});
      add_step("rename skip", 2'b11, 2'b10, {5'd4, 5'd1}, {5'd5, 5'd4}, {5'd5, 5'd4});
      add_step("writeback", 2'b00, 2'b00, '0, '0, '0, 1'b0, 2'b01, {6'd0, 6'd32});
      add_step("wb and rename", 2'b01, 2'b01, {5'd0, 5'd1}, {5'd0, 5'd5}, {5'd0, 5'd6},
               1'b0, 2'b11, {6'd34, 6'd33});
      add_step("credit use", 2'b11, 2'b11, {5'd2, 5'd6}, {5'd1, 5'd5}, {5'd3, 5'd2});
      add_step("credit use", 2'b01, 2'b01, {5'd0, 5'd3}, '0, {5'd0, 5'd4});
      add_step("credit stall", 2'b01, 2'b01, {5'd0, 5'd7}, {5'd0, 5'd1}, {5'd0, 5'd7});
      add_step("credit return", 2'b01, 2'b01, {5'd0, 5'd7}, {5'd0, 5'd1}, {5'd0, 5'd7},
               1'b0, 2'b00, '0, 2'b11);
      add_step("credit release", 2'b01, 2'b01, {5'd0, 5'd7}, {5'd0, 5'd1}, {5'd0, 5'd7});
      add_step("credit refill", 2'b00, 2'b00, '0, '0, '0, 1'b0, 2'b00, '0, 2'b11);
      // Drain the free list with two new tags per step
      for (int k = 0; k < 12; k++)
      begin
         add_step("fill", 2'b11, 2'b11,
                  {rn_pkg::lreg_t'(9 + 2 * k), rn_pkg::lreg_t'(8 + 2 * k)}, '0,
                  {rn_pkg::lreg_t'(9 + 2 * k), rn_pkg::lreg_t'(8 + 2 * k)},
                  1'b0, 2'b00, '0, 2'b11);
      end
      add_step("free list empty", 2'b11, 2'b01, {5'd1, 5'd2}, '0, {5'd3, 5'd2});
      add_step("no destination", 2'b11, 2'b00, {5'd1, 5'd2}, {5'd5, 5'd6}, {5'd3, 5'd2});
      add_step("commit", 2'b00, 2'b00, '0, '0, '0, 1'b1, 2'b00, '0, 2'b11);
      add_step("commit", 2'b00, 2'b00, '0, '0, '0, 1'b1);
      add_step("commit", 2'b00, 2'b00, '0, '0, '0, 1'b1);
      add_step("commit", 2'b00, 2'b00, '0, '0, '0, 1'b1);
      add_step("recycle", 2'b11, 2'b11, {5'd2, 5'd3}, '0, {5'd3, 5'd2}, 1'b0, 2'b00, '0, 2'b11);
      add_step("recycle", 2'b11, 2'b11, {5'd4, 5'd5}, '0, {5'd5, 5'd4});
      // Group would pass if not for the flush
      add_step("flush", 2'b01, 2'b00, {5'd0, 5'd1}, '0, {5'd0, 5'd1}, 1'b0, 2'b00, '0, 2'b00,
               1'b1);
      add_step("after flush", 2'b11, 2'b11, {5'd6, 5'd1}, {5'd7, 5'd5}, {5'd9, 5'd8});
      for (int k = 0; k < 3; k++)
         add_step("flush credits", 2'b11, 2'b11, {5'd8, 5'd9}, '0, {5'd11, 5'd10});
      add_step("flush credit stall", 2'b01, 2'b01, '0, '0, {5'd0, 5'd12});

      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      compare("issue_push", issue_push, '0);
      compare("rn_stall_req", rn_stall_req, 1'b0);
      compare("busytable", busytable, '0);

      for (int i = 0; i < steps.size() && !timed_out; i++)
         run_step(i);

      $display("%0d steps, %0d checks, %0d errors", steps.size(), check_cnt, err_cnt);
      if (err_cnt == 0 && !timed_out)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== logic/rn.sv ====
// Register rename stage top
//   Stall from free-list occupancy and issue credits
//   Credit counter toward the issue queue
//   One-cycle stage register toward issue
//   Free list, alias tables and busy table instances

`timescale 1ns/1ps
`default_nettype none

`include "rn_defines.svh"

module rn (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                flush,
   // Decoded group
   input  logic [`RN_IW-1:0]                   rn_valid,
   input  rn_pkg::uop_payload_t [`RN_IW-1:0]   rn_payload,
   input  rn_pkg::lreg_t [`RN_IW-1:0]          rn_lrs1,
   input  logic [`RN_IW-1:0]                   rn_lrs1_re,
   input  rn_pkg::lreg_t [`RN_IW-1:0]          rn_lrs2,
   input  logic [`RN_IW-1:0]                   rn_lrs2_re,
   input  rn_pkg::lreg_t [`RN_IW-1:0]          rn_lrd,
   input  logic [`RN_IW-1:0]                   rn_lrd_we,
   output logic                                rn_stall_req,
   // Commit
   input  logic                                cmt_fire,
   input  rn_pkg::lreg_t                       cmt_lrd,
   input  rn_pkg::preg_t                       cmt_prd,
   input  logic                                cmt_prd_we,
   input  rn_pkg::preg_t                       cmt_pfree,
   // Writeback
   input  rn_pkg::preg_t [`RN_IW-1:0]          prf_waddr,
   input  logic [`RN_IW-1:0]                   prf_we,
   // Issue queue
   input  logic [`RN_IW-1:0]                   issue_credit,
   output logic [`RN_IW-1:0]                   issue_push,
   output rn_pkg::uop_payload_t [`RN_IW-1:0]   issue_payload,
   output rn_pkg::preg_t [`RN_IW-1:0]          issue_prs1,
   output logic [`RN_IW-1:0]                   issue_prs1_re,
   output rn_pkg::preg_t [`RN_IW-1:0]          issue_prs2,
   output logic [`RN_IW-1:0]                   issue_prs2_re,
   output rn_pkg::lreg_t [`RN_IW-1:0]          issue_lrd,
   output rn_pkg::preg_t [`RN_IW-1:0]          issue_prd,
   output logic [`RN_IW-1:0]                   issue_prd_we,
   output rn_pkg::preg_t [`RN_IW-1:0]          issue_pfree,
   output logic [(1<<`RN_PRF_AW)-1:0]          busytable
);

   localparam int CRW = $clog2(`RN_IQ_DEPTH + 1);
   localparam int NW  = $clog2(`RN_IW + 1);

   logic [CRW-1:0]              credit_cnt;
   logic [NW-1:0]               n_vld;
   logic [NW-1:0]               n_wr;
   logic [NW-1:0]               n_ret;
   logic                        accept;
   logic [`RN_IW-1:0]           fl_pop;
   logic [`RN_PRF_AW-1:0]       fl_free_cnt;
   rn_pkg::preg_t [`RN_IW-1:0]  fl_prd;
   rn_pkg::preg_t [`RN_IW-1:0]  rat_prs1;
   rn_pkg::preg_t [`RN_IW-1:0]  rat_prs2;
   rn_pkg::preg_t [`RN_IW-1:0]  rat_pfree;

   rn_cmt_if u_cmt ();

   assign u_cmt.fire   = cmt_fire;
   assign u_cmt.lrd    = cmt_lrd;
   assign u_cmt.prd    = cmt_prd;
   assign u_cmt.prd_we = cmt_prd_we;
   assign u_cmt.pfree  = cmt_pfree;

   assign n_vld = NW'($countones(rn_valid));
   assign n_wr  = NW'($countones(rn_valid & rn_lrd_we));
   assign n_ret = NW'($countones(issue_credit));

   // Not enough free tags or issue-queue slots for this group
   assign rn_stall_req = (fl_free_cnt < `RN_PRF_AW'(n_wr)) | (credit_cnt < CRW'(n_vld));

   assign accept = (|rn_valid) & ~rn_stall_req & ~flush;
   assign fl_pop = rn_valid & rn_lrd_we & {`RN_IW{accept}};

   rn_fl u_fl (
      .clk         (clk),
      .rst         (rst),
      .pop         (fl_pop),
      .rollback    (flush),
      .cmt         (u_cmt.snk),
      .fl_prd      (fl_prd),
      .fl_free_cnt (fl_free_cnt)
   );

   rn_rat u_rat (
      .clk       (clk),
      .rst       (rst),
      .we        (fl_pop),
      .rollback  (flush),
      .lrs1      (rn_lrs1),
      .lrs2      (rn_lrs2),
      .lrd       (rn_lrd),
      .fl_prd    (fl_prd),
      .cmt       (u_cmt.snk),
      .rat_prs1  (rat_prs1),
      .rat_prs2  (rat_prs2),
      .rat_pfree (rat_pfree)
   );

   rn_busytable u_busytable (
      .clk       (clk),
      .rst       (rst),
      .flush     (flush),
      .prd       (fl_prd),
      .prd_we    (fl_pop),
      .prf_waddr (prf_waddr),
      .prf_we    (prf_we),
      .busytable (busytable)
   );

   // Issue queue is emptied together with a flush
   always_ff @(posedge clk)
   begin
      if (rst || flush)
         credit_cnt <= CRW'(`RN_IQ_DEPTH);
      else
         credit_cnt <= credit_cnt + CRW'(n_ret) - (accept ? CRW'(n_vld) : CRW'(0));
   end

   always_ff @(posedge clk)
   begin
      if (rst || flush)
         issue_push <= '0;
      else
         issue_push <= rn_valid & {`RN_IW{accept}};   // One-cycle pulse
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         issue_payload <= rn_payload;
         issue_prs1    <= rat_prs1;
         issue_prs1_re <= rn_lrs1_re;
         issue_prs2    <= rat_prs2;
         issue_prs2_re <= rn_lrs2_re;
         issue_lrd     <= rn_lrd;
         issue_prd     <= fl_prd;
         issue_prd_we  <= rn_lrd_we;
         issue_pfree   <= rat_pfree;
      end
   end

   // Issue queue must not return more credits than it holds entries
   ap_credit_bound : assert property (
      @(posedge clk) disable iff (rst)
      credit_cnt <= CRW'(`RN_IQ_DEPTH)
   );

endmodule

`default_nettype wire

// ==== logic/rn_busytable.sv ====
// Physical register busy table
//   Set when a tag is allocated at rename
//   Cleared at writeback, all cleared on flush

`timescale 1ns/1ps
`default_nettype none

`include "rn_defines.svh"

module rn_busytable (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            flush,
   input  rn_pkg::preg_t [`RN_IW-1:0]      prd,
   input  logic [`RN_IW-1:0]               prd_we,
   input  rn_pkg::preg_t [`RN_IW-1:0]      prf_waddr,
   input  logic [`RN_IW-1:0]               prf_we,
   output logic [(1<<`RN_PRF_AW)-1:0]      busytable
);

   logic [(1<<`RN_PRF_AW)-1:0] busy_nxt;

   // Clears first so a fresh allocation of the same tag stays busy
   always_comb
   begin
      busy_nxt = busytable;
      for (int j = 0; j < `RN_IW; j++)
      begin
         if (prf_we[j])
            busy_nxt[prf_waddr[j]] = 1'b0;
      end
      for (int i = 0; i < `RN_IW; i++)
      begin
         if (prd_we[i])
            busy_nxt[prd[i]] = 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         busytable <= '0;
      else if (flush)
         busytable <= '0;                    // Nothing in flight survives
      else
         busytable <= busy_nxt;
   end

endmodule

`default_nettype wire

// ==== logic/rn_cmt_if.sv ====
// Commit port toward the rename stage
//   One retiring micro-op per cycle
//   src side at the stage top, snk side at free list and alias table

`timescale 1ns/1ps
`default_nettype none

`include "rn_defines.svh"

interface rn_cmt_if;

   logic          fire;                 // Qualifies everything below
   rn_pkg::lreg_t lrd;
   rn_pkg::preg_t prd;                  // New committed mapping of lrd
   logic          prd_we;
   rn_pkg::preg_t pfree;                // Old mapping, returns to the free list

   modport src (
      output fire,
      output lrd,
      output prd,
      output prd_we,
      output pfree
   );

   modport snk (
      input fire,
      input lrd,
      input prd,
      input prd_we,
      input pfree
   );

endinterface

`default_nettype wire

// ==== logic/rn_defines.svh ====
// Rename stage configuration macros
//   Group width, register file address widths
//   Payload field widths and issue-queue depth

`ifndef RN_DEFINES_SVH
`define RN_DEFINES_SVH

// Micro-ops renamed per cycle
`define RN_IW 2

// 32 logical registers
`define RN_LRF_AW 5

// 64 physical registers
`define RN_PRF_AW 6

// Immediate width
`define RN_DW 64

// Word-aligned pc, low two bits dropped
`define RN_PC_W 62

// Issue-queue entries, also the credit count out of reset
`define RN_IQ_DEPTH 8

`endif

// ==== logic/rn_fl.sv ====
// Physical register free list
//   Circular buffer of free tags, popped at rename
//   Speculative head, committed head and tail
//   Commit pushes the released tag, rollback rewinds the head

`timescale 1ns/1ps
`default_nettype none

`include "rn_defines.svh"

module rn_fl (
   input  logic                            clk,
   input  logic                            rst,
   input  logic [`RN_IW-1:0]               pop,
   input  logic                            rollback,
   rn_cmt_if.snk                           cmt,
   output rn_pkg::preg_t [`RN_IW-1:0]      fl_prd,
   output logic [`RN_PRF_AW-1:0]           fl_free_cnt
);

   // Physical registers not backing a logical one out of reset
   localparam int FL_DEPTH = (1 << `RN_PRF_AW) - (1 << `RN_LRF_AW);
   localparam int FL_AW    = $clog2(FL_DEPTH);

   rn_pkg::preg_t    fifo [FL_DEPTH];
   logic [FL_AW:0]   head;              // Extra bit tells full from empty
   logic [FL_AW:0]   cmt_head;
   logic [FL_AW:0]   tail;
   logic [FL_AW:0]   head_nxt;
   logic [FL_AW:0]   cmt_head_nxt;
   logic [FL_AW:0]   free_cnt;
   logic             release_fire;

   assign release_fire = cmt.fire & cmt.prd_we;
   assign cmt_head_nxt = cmt_head + (FL_AW + 1)'(release_fire);
   assign free_cnt     = tail - head;
   assign fl_free_cnt  = `RN_PRF_AW'(free_cnt);

   // Each popping slot takes the next entry after the earlier poppers
   always_comb
   begin
      logic [FL_AW:0] ptr;
      ptr = head;
      for (int i = 0; i < `RN_IW; i++)
      begin
         fl_prd[i] = fifo[ptr[FL_AW-1:0]];
         ptr       = ptr + pop[i];
      end
      head_nxt = ptr;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         head     <= '0;
         cmt_head <= '0;
         tail     <= (FL_AW + 1)'(FL_DEPTH);   // Full
         for (int k = 0; k < FL_DEPTH; k++)
         begin
            fifo[k] <= rn_pkg::preg_t'((1 << `RN_LRF_AW) + k);
         end
      end
      else
      begin
         if (release_fire)
         begin
            fifo[tail[FL_AW-1:0]] <= cmt.pfree;
            tail                  <= tail + 1'b1;
         end
         cmt_head <= cmt_head_nxt;
         if (rollback)
            head <= cmt_head_nxt;               // Drop speculative pops
         else
            head <= head_nxt;
      end
   end

   // Stall logic in the top must keep pops within the free entries
   ap_no_underflow : assert property (
      @(posedge clk) disable iff (rst)
      $countones(pop) <= free_cnt
   );

   // Committed head never runs ahead of the speculative one
   ap_cmt_behind_spec : assert property (
      @(posedge clk) disable iff (rst)
      (head - cmt_head) <= (FL_AW + 1)'(FL_DEPTH)
   );

endmodule

`default_nettype wire

// ==== logic/rn_pkg.sv ====
// Rename stage types
//   Logical and physical register indices
//   Opcode class enum
//   Pass-through micro-op payload

`default_nettype none

`include "rn_defines.svh"

package rn_pkg;

   typedef logic [`RN_LRF_AW-1:0] lreg_t;
   typedef logic [`RN_PRF_AW-1:0] preg_t;

   // Selects the issue queue downstream
   typedef enum logic [1:0] {
      OP_ALU = 2'd0,
      OP_BRU = 2'd1,
      OP_LSU = 2'd2,
      OP_EPU = 2'd3
   } op_class_e;

   // Not touched by rename
   typedef struct packed {
      op_class_e          op_class;
      logic [7:0]         opc;          // Opaque within the class
      logic [`RN_PC_W-1:0] pc;
      logic [`RN_DW-1:0]   imm;
   } uop_payload_t;

endpackage

`default_nettype wire

// ==== logic/rn_rat.sv ====
// Register alias tables
//   Speculative table written at rename
//   Committed table written at commit
//   Source and old-destination lookups with bypass inside the group
//   Rollback of the speculative table from the committed one

`timescale 1ns/1ps
`default_nettype none

`include "rn_defines.svh"

module rn_rat (
   input  logic                            clk,
   input  logic                            rst,
   input  logic [`RN_IW-1:0]               we,
   input  logic                            rollback,
   input  rn_pkg::lreg_t [`RN_IW-1:0]      lrs1,
   input  rn_pkg::lreg_t [`RN_IW-1:0]      lrs2,
   input  rn_pkg::lreg_t [`RN_IW-1:0]      lrd,
   input  rn_pkg::preg_t [`RN_IW-1:0]      fl_prd,
   rn_cmt_if.snk                           cmt,
   output rn_pkg::preg_t [`RN_IW-1:0]      rat_prs1,
   output rn_pkg::preg_t [`RN_IW-1:0]      rat_prs2,
   output rn_pkg::preg_t [`RN_IW-1:0]      rat_pfree
);

   localparam int NLREG = 1 << `RN_LRF_AW;

   rn_pkg::preg_t spec_tab [NLREG];
   rn_pkg::preg_t cmt_tab  [NLREG];
   logic          cmt_upd;

   assign cmt_upd = cmt.fire & cmt.prd_we;

   // Table read, then override by older slots of the same group
   always_comb
   begin
      for (int i = 0; i < `RN_IW; i++)
      begin
         rat_prs1[i]  = spec_tab[lrs1[i]];
         rat_prs2[i]  = spec_tab[lrs2[i]];
         rat_pfree[i] = spec_tab[lrd[i]];
         // Youngest older writer wins, so scan in order
         for (int j = 0; j < i; j++)
         begin
            if (we[j] && (lrd[j] == lrs1[i]))
               rat_prs1[i] = fl_prd[j];
            if (we[j] && (lrd[j] == lrs2[i]))
               rat_prs2[i] = fl_prd[j];
            if (we[j] && (lrd[j] == lrd[i]))
               rat_pfree[i] = fl_prd[j];   // Replaces the older slot's tag
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int k = 0; k < NLREG; k++)
         begin
            spec_tab[k] <= rn_pkg::preg_t'(k);    // Identity map
            cmt_tab[k]  <= rn_pkg::preg_t'(k);
         end
      end
      else
      begin
         if (cmt_upd)
            cmt_tab[cmt.lrd] <= cmt.prd;

         if (rollback)
         begin
            for (int k = 0; k < NLREG; k++)
            begin
               spec_tab[k] <= cmt_tab[k];
            end
            // Same-cycle commit must survive the restore
            if (cmt_upd)
               spec_tab[cmt.lrd] <= cmt.prd;
         end
         else
         begin
            for (int i = 0; i < `RN_IW; i++)
            begin
               if (we[i])
                  spec_tab[lrd[i]] <= fl_prd[i];   // Later slot overrides
            end
         end
      end
   end

   // The stage top blocks acceptance during a flush
   ap_no_rename_on_rollback : assert property (
      @(posedge clk) disable iff (rst)
      rollback |-> (we == '0)
   );

endmodule

`default_nettype wire

// ==== rn.f ====
+incdir+logic
logic/rn_pkg.sv
logic/rn_cmt_if.sv
logic/rn_fl.sv
logic/rn_rat.sv
logic/rn_busytable.sv
logic/rn.sv
dv/rn_tb.sv
